// ==== hdl/dmc_pkg.sv ====
package dmc_pkg;

  typedef logic [7:0]  sample_t;
  typedef logic [14:0] addr_t;
  typedef logic [6:0]  level_t;
  typedef logic [11:0] length_t;
  typedef logic [3:0]  rate_t;
  typedef logic [8:0]  period_t;

  localparam logic [2:0] REG_CTRL   = 3'd0;
  localparam logic [2:0] REG_DIRECT = 3'd1;
  localparam logic [2:0] REG_ADDR   = 3'd2;
  localparam logic [2:0] REG_LENGTH = 3'd3;
  localparam logic [2:0] REG_STATUS = 3'd4;

  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [2:0] paddr;
    sample_t    pwdata;
  } apb_req_t;

  // STATUS read layout
  typedef struct packed {
    logic       irq;
    logic [5:0] reserved;
    logic       active;
  } dmc_status_t;

  typedef struct packed {
    rate_t   rate;
    logic    loop;
    logic    dma_disable;
    logic    irq_clear;      // Single cpu_clk_en cycle pulses
    logic    addr_load;
    logic    length_load;
    logic    direct_load;
    sample_t addr_reg;
    sample_t length_reg;
    level_t  direct_level;
  } dmc_ctrl_t;

  function automatic period_t rate_period(rate_t rate);
    case (rate)
      4'd0:    return 9'd428;
      4'd1:    return 9'd380;
      4'd2:    return 9'd340;
      4'd3:    return 9'd320;
      4'd4:    return 9'd286;
      4'd5:    return 9'd254;
      4'd6:    return 9'd226;
      4'd7:    return 9'd214;
      4'd8:    return 9'd190;
      4'd9:    return 9'd160;
      4'd10:   return 9'd142;
      4'd11:   return 9'd128;
      4'd12:   return 9'd106;
      4'd13:   return 9'd84;
      4'd14:   return 9'd72;
      default: return 9'd54;
    endcase
  endfunction

endpackage : dmc_pkg

// ==== hdl/divider.sv ====
`timescale 1ns/100ps

module divider
  import dmc_pkg::*;
#(
  parameter int WIDTH = $bits(period_t)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clk_en,
  input  logic [WIDTH-1:0] period,
  output logic             pulse
);

  logic [WIDTH-1:0] count;

  // One pulse every period enabled cycles
  assign pulse = clk_en && (count == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clk_en) begin
      if (count == '0) begin
        count <= period - 1'b1;  // Reload
      end else begin
        count <= count - 1'b1;
      end
    end
  end

endmodule : divider

// ==== hdl/dmc_regs.sv ====
`timescale 1ns/100ps

module dmc_regs
  import dmc_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cpu_clk_en,
  input  apb_req_t  apb,
  output sample_t   prdata,
  output logic      pready,
  input  logic      active,
  input  logic      irq,
  output dmc_ctrl_t ctrl
);

  logic        access;
  logic        wr;
  dmc_status_t status;

  rate_t       rate;
  logic        loop;
  logic        dma_disable;
  logic        irq_clear;
  logic        addr_load;
  logic        length_load;
  logic        direct_load;
  sample_t     addr_reg;
  sample_t     length_reg;
  level_t      direct_level;

  assign access = apb.psel && apb.penable;
  assign wr     = access && apb.pwrite;
  assign pready = access;  // No wait states

  assign status = '{irq: irq, reserved: '0, active: active};
  assign prdata = (access && !apb.pwrite && apb.paddr == REG_STATUS) ? sample_t'(status) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rate        <= '0;
      loop        <= 1'b0;
      dma_disable <= 1'b0;
    end else if (wr && apb.paddr == REG_CTRL) begin
      rate        <= apb.pwdata[3:0];
      loop        <= apb.pwdata[6];
      dma_disable <= apb.pwdata[7];
    end
  end

  // Pulses stay up until the next cpu_clk_en cycle has seen them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_clear   <= 1'b0;
      addr_load   <= 1'b0;
      length_load <= 1'b0;
      direct_load <= 1'b0;
    end else begin
      if (cpu_clk_en) begin
        irq_clear   <= 1'b0;
        addr_load   <= 1'b0;
        length_load <= 1'b0;
        direct_load <= 1'b0;
      end
      if (wr && apb.paddr == REG_STATUS && apb.pwdata[7]) irq_clear <= 1'b1;
      if (wr && apb.paddr == REG_ADDR)   addr_load   <= 1'b1;
      if (wr && apb.paddr == REG_LENGTH) length_load <= 1'b1;
      if (wr && apb.paddr == REG_DIRECT) direct_load <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      case (apb.paddr)
        REG_DIRECT: direct_level <= apb.pwdata[6:0];
        REG_ADDR:   addr_reg     <= apb.pwdata;
        REG_LENGTH: length_reg   <= apb.pwdata;
        default:    ;
      endcase
    end
  end

  assign ctrl = '{
    rate:         rate,
    loop:         loop,
    dma_disable:  dma_disable,
    irq_clear:    irq_clear,
    addr_load:    addr_load,
    length_load:  length_load,
    direct_load:  direct_load,
    addr_reg:     addr_reg,
    length_reg:   length_reg,
    direct_level: direct_level
  };

endmodule : dmc_regs

// ==== hdl/memory_reader.sv ====
`timescale 1ns/100ps

module memory_reader
  import dmc_pkg::*;
#(
  parameter bit ADDR_BASE_BIT = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cpu_clk_en,
  input  dmc_ctrl_t ctrl,
  input  logic      buffer_empty,
  output logic      mem_re,
  output addr_t     mem_addr,
  output logic      active,
  output logic      irq
);

  addr_t   start_addr;
  length_t sample_length;
  length_t count;
  logic    fetch;
  logic    last;
  logic    restart;

  assign start_addr    = {ADDR_BASE_BIT, ctrl.addr_reg, 6'b0};
  assign sample_length = {ctrl.length_reg, 4'b0001};  // length*16 + 1

  assign active = (count != '0) && !ctrl.dma_disable;
  assign mem_re = buffer_empty && active;
  assign fetch  = cpu_clk_en && mem_re;
  assign last   = (count == length_t'(1));

  assign restart = fetch && last && ctrl.loop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (cpu_clk_en) begin
      if (ctrl.dma_disable) begin
        count <= '0;
      end else if (ctrl.length_load || restart) begin
        count <= sample_length;
      end else if (fetch) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_addr <= '0;
    end else if (cpu_clk_en) begin
      if (ctrl.addr_load || ctrl.length_load || restart) begin
        mem_addr <= start_addr;
      end else if (fetch) begin
        mem_addr <= mem_addr + 1'b1;  // Wraps 0x7FFF to 0
      end
    end
  end

  // End of a pass without loop raises irq
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else if (cpu_clk_en) begin
      if (fetch && last && !ctrl.loop) begin
        irq <= 1'b1;
      end else if (ctrl.irq_clear) begin
        irq <= 1'b0;
      end
    end
  end

endmodule : memory_reader

// ==== hdl/sample_buffer.sv ====
`timescale 1ns/100ps

module sample_buffer
  import dmc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cpu_clk_en,
  input  logic    load,
  input  logic    read,
  input  sample_t data_in,
  output logic    empty,
  output sample_t data_out
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      empty <= 1'b1;
    end else if (cpu_clk_en) begin
      if (load && empty) begin
        empty <= 1'b0;
      end else if (read && !empty) begin
        empty <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_clk_en && load && empty) begin
      data_out <= data_in;
    end
  end

endmodule : sample_buffer

// ==== hdl/output_unit.sv ====
`timescale 1ns/100ps

module output_unit
  import dmc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cpu_clk_en,
  input  logic    tick,
  input  logic    buffer_empty,
  input  sample_t buffer_data,
  input  logic    direct_load,
  input  level_t  direct_level,
  output logic    buffer_read,
  output level_t  level
);

  logic    new_cycle;
  logic    silence;
  sample_t shift_data;
  level_t  level_next;

  // Eight ticks per output byte
  divider #(.WIDTH(4)) bit_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .clk_en (tick),
    .period (4'd8),
    .pulse  (new_cycle)
  );

  assign buffer_read = new_cycle && !buffer_empty;

  always_comb begin
    level_next = level;
    if (tick && !silence) begin
      if (shift_data[0] && level <= 7'd125) begin
        level_next = level + 7'd2;
      end else if (!shift_data[0] && level >= 7'd2) begin
        level_next = level - 7'd2;
      end
    end
    if (direct_load) begin
      level_next = direct_level;  // Overrides delta step
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else if (cpu_clk_en) begin
      level <= level_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      silence <= 1'b1;
    end else if (cpu_clk_en && new_cycle) begin
      silence <= buffer_empty;  // No byte, silent cycle
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_clk_en) begin
      if (buffer_read) begin
        shift_data <= buffer_data;
      end else if (tick) begin
        shift_data <= shift_data >> 1;  // LSB first
      end
    end
  end

endmodule : output_unit

// ==== hdl/dmc_top.sv ====
`timescale 1ns/100ps

module dmc_top
  import dmc_pkg::*;
#(
  parameter bit ADDR_BASE_BIT = 1'b1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cpu_clk_en,
  input  apb_req_t apb,
  output sample_t  prdata,
  output logic     pready,
  output logic     mem_re,
  output addr_t    mem_addr,
  input  sample_t  mem_data,
  output logic     irq,
  output level_t   level
);

  dmc_ctrl_t ctrl;
  logic      active;
  logic      buffer_empty;
  logic      buffer_read;
  logic      tick;
  sample_t   buffer_data;

  dmc_regs regs (
    .clk, .rst_n, .cpu_clk_en, .apb, .prdata, .pready,
    .active, .irq, .ctrl);

  memory_reader #(.ADDR_BASE_BIT(ADDR_BASE_BIT)) reader (
    .clk, .rst_n, .cpu_clk_en, .ctrl, .buffer_empty,
    .mem_re, .mem_addr, .active, .irq);

  sample_buffer buffer (
    .clk, .rst_n, .cpu_clk_en,
    .load     (mem_re),  // A fetch fills the empty buffer
    .read     (buffer_read),
    .data_in  (mem_data),
    .empty    (buffer_empty),
    .data_out (buffer_data));

  divider #(.WIDTH($bits(period_t))) rate_timer (
    .clk, .rst_n,
    .clk_en (cpu_clk_en),
    .period (rate_period(ctrl.rate)),
    .pulse  (tick));

  output_unit out_unit (
    .clk, .rst_n, .cpu_clk_en, .tick, .buffer_empty, .buffer_data,
    .direct_load  (ctrl.direct_load),
    .direct_level (ctrl.direct_level),
    .buffer_read, .level);

endmodule : dmc_top

// ==== test/dmc_asserts.sv ====
`timescale 1ns/100ps

module dmc_asserts
  import dmc_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input apb_req_t apb,
  input logic     pready,
  input logic     mem_re,
  input level_t   level,
  input logic     direct_load,
  input logic     dma_disable
);

  // No wait states on the APB side
  pready_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) (apb.psel && apb.penable) |-> pready
  ) else $error("pready low in an APB access phase");

  // A delta step never wraps past either end of the 7-bit range
  level_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    !direct_load |=> ((level >= $past(level)) ? (level - $past(level) <= 7'd2)
                                              : ($past(level) - level <= 7'd2))
  ) else $error("output level left the 0 to 127 range");

  no_fetch_when_disabled: assert property (
    @(posedge clk) disable iff (!rst_n) dma_disable |-> !mem_re
  ) else $error("memory read while the channel is disabled");

endmodule : dmc_asserts

bind dmc_top dmc_asserts asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .apb         (apb),
  .pready      (pready),
  .mem_re      (mem_re),
  .level       (level),
  .direct_load (ctrl.direct_load),
  .dma_disable (ctrl.dma_disable)
);

// ==== test/dmc_tb.sv ====
`timescale 1ns/100ps

module dmc_tb
  import dmc_pkg::*;
();

  localparam int     CLK_NS    = 4;
  localparam int     NUM_TESTS = 16;
  localparam int     MAX_BYTES = 4 * 16 + 1;  // Longest sample used
  localparam longint WATCHDOG_NS =
    longint'(NUM_TESTS) * MAX_BYTES * 8 * 428 * 2 * CLK_NS;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       cpu_clk_en = 1'b0;
  apb_req_t   apb;
  sample_t    prdata;
  logic       pready;
  logic       mem_re;
  addr_t      mem_addr;
  sample_t    mem_data;
  logic       irq;
  level_t     level;

  int         seed = 91380;
  int         en_draw;
  logic [1:0] fill_mode;  // 0 address pattern, 1 all ones, 2 all zeros
  logic [1:0] slope;      // 0 either way, 1 rising only, 2 falling only

  // Reference model
  logic       m_loop;
  logic       m_disable;
  logic       m_irq;
  sample_t    m_addr_reg;
  sample_t    m_length_reg;
  level_t     m_direct;
  length_t    m_count;
  addr_t      m_addr;
  int         addr_req, length_req, clear_req, direct_req;
  int         addr_seen, length_seen, clear_seen, direct_seen;
  logic       direct_check;
  logic       fetch_now;
  logic       last_fetch;
  level_t     prev_level;
  int         step;
  int         fetch_count;
  int         pass_count;

  dmc_top #(.ADDR_BASE_BIT(1'b1)) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_clk_en (cpu_clk_en),
    .apb        (apb),
    .prdata     (prdata),
    .pready     (pready),
    .mem_re     (mem_re),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .irq        (irq),
    .level      (level)
  );

  always #(CLK_NS / 2) clk = ~clk;

  always begin
    @(posedge clk);
    #1;
    en_draw = $random(seed);
    cpu_clk_en = en_draw[0];  // About every other cycle
  end

  function automatic sample_t memory_byte(addr_t a, logic [1:0] mode);
    case (mode)
      2'd1:    return 8'hFF;
      2'd2:    return 8'h00;
      default: return a[7:0] ^ {1'b0, a[14:8]};
    endcase
  endfunction

  assign mem_data = memory_byte(mem_addr, fill_mode);

  function automatic addr_t start_address();
    return addr_t'((32'hC000 + 64 * int'(m_addr_reg)) & 32'h7FFF);
  endfunction

  function automatic length_t pass_length();
    return length_t'(16 * int'(m_length_reg) + 1);
  endfunction

  function automatic logic model_active();
    return (m_count != '0) && !m_disable;
  endfunction

  task automatic end_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("error at %0t ns: %s", $time, what);
    end_with_failure();
  endtask

  task automatic compare_value(input string what, input int actual, input int expected);
    if (actual != expected) begin
      $display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      end_with_failure();
    end
  endtask

  // Applies the coming clock-enabled edge to the model
  task automatic advance_model();
    logic addr_pend;
    logic length_pend;
    logic clear_pend;
    logic restart;
    addr_pend   = (addr_req != addr_seen);
    length_pend = (length_req != length_seen);
    clear_pend  = (clear_req != clear_seen);
    restart     = last_fetch && m_loop;
    if (last_fetch) pass_count++;
    if (last_fetch && !m_loop) begin
      m_irq = 1'b1;
    end else if (clear_pend) begin
      m_irq = 1'b0;
    end
    if (m_disable) begin
      m_count = '0;
    end else if (length_pend || restart) begin
      m_count = pass_length();
    end else if (fetch_now) begin
      m_count = m_count - 1'b1;
    end
    if (addr_pend || length_pend || restart) begin
      m_addr = start_address();
    end else if (fetch_now) begin
      m_addr = m_addr + 1'b1;
    end
    if (direct_req != direct_seen) direct_check = 1'b1;
    addr_seen   = addr_req;
    length_seen = length_req;
    clear_seen  = clear_req;
    direct_seen = direct_req;
  endtask

  // Inputs are stable here for the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      compare_value("irq output", int'(irq), int'(m_irq));
      fetch_now  = cpu_clk_en && mem_re;
      last_fetch = fetch_now && (m_count == length_t'(1));
      if (fetch_now) begin
        if (m_disable || m_count == '0) report_error("memory fetch while the reader is idle");
        compare_value("fetch address", int'(mem_addr), int'(m_addr));
        fetch_count++;
      end
      if (direct_check) begin
        compare_value("direct level", int'(level), int'(m_direct));
        direct_check = 1'b0;
      end else if (level != prev_level) begin
        step = int'(level) - int'(prev_level);
        if (slope == 2'd1) begin
          compare_value("rising level step", step, 2);
        end else if (slope == 2'd2) begin
          compare_value("falling level step", step, -2);
        end else begin
          compare_value("level step size", (step < 0) ? -step : step, 2);
        end
      end
      prev_level = level;
      if (cpu_clk_en) advance_model();
    end
  end

  task automatic apb_write(input logic [2:0] addr, input sample_t data);
    @(posedge clk);
    #1;
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    #1;
    apb.penable = 1'b1;
    @(posedge clk);  // Write lands here
    #1;
    apb = '0;
    case (addr)
      REG_CTRL: begin
        m_loop    = data[6];
        m_disable = data[7];
      end
      REG_DIRECT: begin
        m_direct = data[6:0];
        direct_req++;
      end
      REG_ADDR: begin
        m_addr_reg = data;
        addr_req++;
      end
      REG_LENGTH: begin
        m_length_reg = data;
        length_req++;
      end
      default: if (data[7]) clear_req++;
    endcase
  endtask

  task automatic read_status(output sample_t value);
    sample_t expected;
    @(posedge clk);
    #1;
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: REG_STATUS, pwdata: '0};
    @(posedge clk);
    #1;
    apb.penable = 1'b1;
    #0.5;
    expected = {m_irq, 6'b0, model_active()};
    compare_value("pready in access phase", int'(pready), 1);
    compare_value("status read", int'(prdata), int'(expected));
    value = prdata;
    @(posedge clk);
    #1;
    apb = '0;
  endtask

  task automatic stop_sample();
    apb_write(REG_CTRL, 8'h80);
    wait (m_count == '0);
    @(posedge clk);
  endtask

  task automatic clear_irq();
    apb_write(REG_STATUS, 8'h80);
    wait (clear_seen == clear_req);
    @(posedge clk);
  endtask

  task automatic load_direct(input level_t value);
    apb_write(REG_DIRECT, {1'b0, value});
    wait (direct_seen == direct_req && !direct_check);
  endtask

  // Mode 1 ramps up from 0, mode 2 ramps down from 127
  task automatic run_level_ramp(input logic [1:0] mode);
    int     fbase;
    level_t held;
    @(posedge clk);
    #1;
    fill_mode = mode;
    slope     = 2'd0;
    apb_write(REG_CTRL, 8'h4F);
    fbase = fetch_count;
    apb_write(REG_LENGTH, 8'h00);
    wait (fetch_count >= fbase + 3);  // Old bytes flushed
    load_direct((mode == 2'd1) ? 7'd0 : 7'd127);
    slope = mode;
    wait ((mode == 2'd1) ? (level >= 7'd126) : (level <= 7'd1));
    slope = 2'd0;
    held  = level;
    fbase = fetch_count;
    wait (fetch_count >= fbase + 2);
    compare_value("level held at its limit", int'(level), int'(held));
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before the tests finished");
  end

  initial begin
    sample_t status;
    sample_t len;
    int      r;
    int      fbase;
    int      base;
    rst_n        = 1'b0;
    apb          = '0;
    fill_mode    = 2'd0;
    slope        = 2'd0;
    {m_loop, m_disable, m_irq, direct_check} = '0;
    {m_addr_reg, m_length_reg, m_direct}     = '0;
    m_count      = '0;
    m_addr       = '0;
    {addr_req, length_req, clear_req, direct_req}     = '0;
    {addr_seen, length_seen, clear_seen, direct_seen} = '0;
    prev_level   = '0;
    fetch_count  = 0;
    pass_count   = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    read_status(status);
    compare_value("status after reset", int'(status), 0);

    repeat (6) begin
      r = $random(seed);
      apb_write(REG_CTRL, {r[7:6], 2'b00, r[3:0]});
      r = $random(seed);
      apb_write(REG_ADDR, r[7:0]);
      apb_write(REG_LENGTH, {6'b0, r[9:8]});
      repeat (r[14:10]) @(posedge clk);
      read_status(status);
    end

    for (int i = 0; i < 4; i++) begin
      stop_sample();
      clear_irq();
      apb_write(REG_CTRL, 8'h0F);
      r = $random(seed);
      apb_write(REG_ADDR, (i == 0) ? 8'hFF : r[7:0]);  // 0xFF runs past 0x7FFF
      len = (i == 0) ? 8'd4 : {6'b0, r[9:8]};
      fbase = fetch_count;
      apb_write(REG_LENGTH, len);
      wait (irq === 1'b1);
      compare_value("bytes fetched in one pass", fetch_count - fbase, 16 * int'(len) + 1);
      read_status(status);
      compare_value("irq after a pass", int'(status[7]), 1);
      clear_irq();
      read_status(status);
      compare_value("irq after clear", int'(status[7]), 0);
    end

    stop_sample();
    apb_write(REG_CTRL, 8'h4F);
    r = $random(seed);
    apb_write(REG_ADDR, r[7:0]);
    fbase = fetch_count;
    base  = pass_count;
    apb_write(REG_LENGTH, 8'h01);
    wait (pass_count >= base + 2);
    compare_value("bytes fetched in two looped passes", fetch_count - fbase, 34);
    read_status(status);
    compare_value("irq with loop set", int'(status[7]), 0);
    compare_value("active with loop set", int'(status[0]), 1);

    apb_write(REG_CTRL, 8'hCF);
    fbase = fetch_count;
    repeat (40) @(posedge clk);
    compare_value("fetches while disabled", fetch_count - fbase, 0);
    read_status(status);
    compare_value("active while disabled", int'(status[0]), 0);

    run_level_ramp(2'd1);
    run_level_ramp(2'd2);

    fill_mode = 2'd0;
    repeat (4) begin
      r = $random(seed);
      load_direct(r[6:0]);
    end
    stop_sample();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : dmc_tb

// ==== vlog.f ====
hdl/dmc_pkg.sv
hdl/divider.sv
hdl/dmc_regs.sv
hdl/memory_reader.sv
hdl/sample_buffer.sv
hdl/output_unit.sv
hdl/dmc_top.sv
test/dmc_asserts.sv
test/dmc_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = dmc_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
